/* verilog/rdmx_pkg.sv */
/*
 * Shared definitions for the RDMX receive checker: beat geometry, header
 * field positions, packet constants, error bit indices and common types
 */
package rdmx_pkg;

    // ========================================
    // Beat geometry
    // ========================================
    localparam int beat_w     = 512;
    localparam int beat_bytes = 64;

    // ========================================
    // Packet constants
    // ========================================
    // Every RDMX packet carries this value in its magic field
    localparam logic [15:0] rdmx_magic = 16'h0122;

    // IPv4 length is the payload plus the IP, UDP and RDMX headers
    localparam int packet_overhead  = 50;
    localparam int md_payload_bytes = 128;
    localparam int fc_payload_bytes = 4;

    // Body beats per packet, the header beat not included
    localparam int md_beats = 2;
    localparam int fc_beats = 1;

    // Low bit of each header field in the byte-swapped (network order) beat
    localparam int pos_ip4_length   = 368;
    localparam int pos_rdmx_magic   = 160;
    localparam int pos_rdmx_address = 96;
    localparam int pos_rdmx_seq     = 80;

    // ========================================
    // Error vector
    // ========================================
    localparam int err_w = 18;

    // Frame-data group; the meta-data and frame-counter groups repeat it
    localparam int err_fd_magic = 0;
    localparam int err_fd_seq   = 1;
    localparam int err_fd_psize = 2;
    localparam int err_fd_taddr = 3;
    localparam int err_fd_data  = 4;
    localparam int err_fd_plen  = 5;
    localparam int err_md_magic = 6;
    localparam int err_md_seq   = 7;
    localparam int err_md_psize = 8;
    localparam int err_md_taddr = 9;
    localparam int err_md_data  = 10;
    localparam int err_md_plen  = 11;
    localparam int err_fc_magic = 12;
    localparam int err_fc_seq   = 13;
    localparam int err_fc_psize = 14;
    localparam int err_fc_taddr = 15;
    localparam int err_fc_data  = 16;
    localparam int err_fc_plen  = 17;

    // ========================================
    // Types
    // ========================================
    typedef logic [63:0] addr_t;
    typedef logic [63:0] count_t;

    typedef enum logic [2:0] {
        get_pattern,
        fd_header,
        fd_body,
        md_header,
        md_body,
        fc_header,
        fc_body
    } checker_state_t;

endpackage

/* verilog/rdmx_beat_if.sv */
/*
 * Registered Ethernet beat with its RDMX header fields already sliced
 */
`timescale 1ns/10ps

interface rdmx_beat_if;

    // One-cycle pulse per accepted beat
    logic                        valid;
    logic                        last;
    // High when tuser was low on this beat
    logic                        well_formed;
    // Beat exactly as it arrived, little-endian
    logic [rdmx_pkg::beat_w-1:0] le_data;
    logic [15:0]                 magic;
    rdmx_pkg::addr_t             address;
    logic [15:0]                 seq;
    logic [15:0]                 ip4_length;
    logic [31:0]                 frame_counter;

    modport src (output valid, last, well_formed, le_data, magic, address, seq,
                 ip4_length, frame_counter);
    modport dst (input valid, last, well_formed, le_data, magic, address, seq,
                 ip4_length, frame_counter);

endinterface

/* verilog/rdmx_ingress.sv */
/*
 * Ingress stage: byte swap, RDMX header slicing and one register stage
 */
`timescale 1ns/10ps

module rdmx_ingress (
    input  logic                        clk,
    input  logic [rdmx_pkg::beat_w-1:0] eth_data,
    input  logic                        eth_valid,
    input  logic                        eth_last,
    input  logic                        eth_user,
    input  logic                        eth_ready,
    rdmx_beat_if.src                    beat
);

    logic [rdmx_pkg::beat_w-1:0] be_data;
    logic                        handshake;

    // A beat moves only when both sides agree
    assign handshake = eth_valid & eth_ready;

    // ========================================
    // Byte reversal
    // ========================================
    // The MAC delivers byte 0 in the low lane; header fields are defined
    // in network order with byte 0 at the top
    always_comb begin
        for (int i = 0; i < rdmx_pkg::beat_bytes; i++) begin
            be_data[8*i +: 8] = eth_data[rdmx_pkg::beat_w - 8*(i+1) +: 8];
        end
    end

    // ========================================
    // Register stage
    // ========================================
    // valid marks each accepted beat for exactly one cycle
    always_ff @(posedge clk) begin
        beat.valid <= handshake;
        if (handshake) begin
            beat.last          <= eth_last;
            beat.well_formed   <= ~eth_user;
            beat.le_data       <= eth_data;
            beat.magic         <= be_data[rdmx_pkg::pos_rdmx_magic +: 16];
            beat.address       <= be_data[rdmx_pkg::pos_rdmx_address +: 64];
            beat.seq           <= be_data[rdmx_pkg::pos_rdmx_seq +: 16];
            beat.ip4_length    <= be_data[rdmx_pkg::pos_ip4_length +: 16];
            // The frame counter sits in the first four bytes as received
            beat.frame_counter <= eth_data[31:0];
        end
    end

endmodule

/* verilog/rdmx_addr_tracker.sv */
/*
 * Expected RDMX target addresses for frame-data and meta-data packets
 */
`timescale 1ns/10ps

module rdmx_addr_tracker (
    input  logic            clk,
    input  logic            resetn,
    input  logic            inc_fd,
    input  logic            inc_md,
    input  logic [15:0]     packet_size,
    input  rdmx_pkg::addr_t rfd_addr,
    input  rdmx_pkg::addr_t rfd_size,
    input  rdmx_pkg::addr_t rmd_addr,
    input  rdmx_pkg::addr_t rmd_size,
    output rdmx_pkg::addr_t fd_addr,
    output rdmx_pkg::addr_t md_addr
);

    // Offsets into each window, always below the window size
    rdmx_pkg::addr_t fd_offs;
    rdmx_pkg::addr_t md_offs;

    // Advance an offset by one packet, going back to 0 at the window end
    function automatic rdmx_pkg::addr_t step_offset(input rdmx_pkg::addr_t offs,
                                                    input rdmx_pkg::addr_t step,
                                                    input rdmx_pkg::addr_t size);
        rdmx_pkg::addr_t nxt;
        nxt = offs + step;
        return (nxt < size) ? nxt : '0;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fd_offs <= '0;
            md_offs <= '0;
        end else begin
            if (inc_fd)
                fd_offs <= step_offset(fd_offs, rdmx_pkg::addr_t'(packet_size), rfd_size);
            if (inc_md)
                md_offs <= step_offset(md_offs, rdmx_pkg::addr_t'(rdmx_pkg::md_payload_bytes),
                                       rmd_size);
        end
    end

    assign fd_addr = rfd_addr + fd_offs;
    assign md_addr = rmd_addr + md_offs;

endmodule

/* verilog/rdmx_frame_checker.sv */
/*
 * Packet sequence FSM with header, data and length checks,
 * sticky error bits and packet counters
 */
`timescale 1ns/10ps

module rdmx_frame_checker (
    input  logic                       clk,
    input  logic                       resetn,
    rdmx_beat_if.dst                   beat,
    input  logic [31:0]                pattern_data,
    input  logic                       pattern_valid,
    input  logic [15:0]                packet_size,
    input  logic [31:0]                frame_size,
    input  rdmx_pkg::addr_t            fd_addr,
    input  rdmx_pkg::addr_t            md_addr,
    input  rdmx_pkg::addr_t            rfc_addr,
    output logic                       pattern_ready,
    output logic                       eth_ready,
    output logic                       inc_fd,
    output logic                       inc_md,
    output rdmx_pkg::count_t           total_packets,
    output rdmx_pkg::count_t           malformed_packets,
    output logic [31:0]                expected_fc,
    output logic [rdmx_pkg::err_w-1:0] error,
    output logic                       all_good
);

    rdmx_pkg::checker_state_t    state, next_state;
    logic [rdmx_pkg::beat_w-1:0] exp_data;
    logic [15:0]                 exp_seq;
    // Body beats seen so far in the current packet, 1-based
    logic [15:0]                 beat_count;
    // Frame-data packets seen so far in this half-frame
    logic [31:0]                 fd_count;
    logic [15:0]                 beats_per_fd;
    logic [31:0]                 packets_per_hframe;
    // Expectations for the packet kind the FSM is currently in
    logic [4:0]                  err_base;
    logic [15:0]                 exp_ip4_length;
    rdmx_pkg::addr_t             exp_addr;
    logic [15:0]                 exp_beats;

    // Bit position of the single set bit in a power of two
    function automatic logic [4:0] log2_pow2(input logic [15:0] v);
        logic [4:0] r;
        r = '0;
        for (int i = 0; i < 16; i++) begin
            if (v[i])
                r = 5'(i);
        end
        return r;
    endfunction

    assign beats_per_fd       = packet_size / 16'(rdmx_pkg::beat_bytes);
    // This channel sees only half of the packets of each frame
    assign packets_per_hframe = (frame_size >> log2_pow2(packet_size)) >> 1;

    assign all_good      = (error == '0);
    // After an error both streams drain freely
    assign pattern_ready = resetn & ((state == rdmx_pkg::get_pattern) | ~all_good);
    assign eth_ready     = resetn & ((state != rdmx_pkg::get_pattern) | ~all_good);

    // ========================================
    // Expectations and next state
    // ========================================
    always_comb begin
        err_base       = 5'(rdmx_pkg::err_fd_magic);
        exp_ip4_length = packet_size + 16'(rdmx_pkg::packet_overhead);
        exp_addr       = fd_addr;
        exp_beats      = beats_per_fd;
        if (state == rdmx_pkg::md_header || state == rdmx_pkg::md_body) begin
            err_base       = 5'(rdmx_pkg::err_md_magic);
            exp_ip4_length = 16'(rdmx_pkg::md_payload_bytes + rdmx_pkg::packet_overhead);
            exp_addr       = md_addr;
            exp_beats      = 16'(rdmx_pkg::md_beats);
        end else if (state == rdmx_pkg::fc_header || state == rdmx_pkg::fc_body) begin
            err_base       = 5'(rdmx_pkg::err_fc_magic);
            exp_ip4_length = 16'(rdmx_pkg::fc_payload_bytes + rdmx_pkg::packet_overhead);
            exp_addr       = rfc_addr;
            exp_beats      = 16'(rdmx_pkg::fc_beats);
        end

        case (state)
            rdmx_pkg::get_pattern: next_state = rdmx_pkg::fd_header;
            rdmx_pkg::fd_header:   next_state = rdmx_pkg::fd_body;
            // Meta-data follows once the half-frame is complete
            rdmx_pkg::fd_body:     next_state = (fd_count == packets_per_hframe) ?
                                                rdmx_pkg::md_header : rdmx_pkg::fd_header;
            rdmx_pkg::md_header:   next_state = rdmx_pkg::md_body;
            rdmx_pkg::md_body:     next_state = rdmx_pkg::fc_header;
            rdmx_pkg::fc_header:   next_state = rdmx_pkg::fc_body;
            default:               next_state = rdmx_pkg::get_pattern;
        endcase
    end

    // ========================================
    // Sequence FSM and counters
    // ========================================
    always_ff @(posedge clk) begin
        inc_fd <= 1'b0;
        inc_md <= 1'b0;
        if (!resetn) begin
            state             <= rdmx_pkg::get_pattern;
            error             <= '0;
            total_packets     <= '0;
            malformed_packets <= '0;
            expected_fc       <= '0;
            exp_seq           <= 16'd1;
            beat_count        <= '0;
            fd_count          <= '0;
        end else begin
            // Bad FCS packets are counted even after checking has stopped
            if (beat.valid && beat.last && !beat.well_formed)
                malformed_packets <= malformed_packets + 1'b1;

            if (all_good) begin
                if (beat.valid)
                    beat_count <= beat_count + 1'b1;
                if (beat.valid && beat.last) begin
                    total_packets <= total_packets + 1'b1;
                    exp_seq       <= exp_seq + 1'b1;
                end

                case (state)
                    rdmx_pkg::get_pattern:
                        if (pattern_valid) begin
                            exp_data    <= {(rdmx_pkg::beat_w / 32){pattern_data}};
                            expected_fc <= expected_fc + 1'b1;
                            fd_count    <= '0;
                            state       <= next_state;
                        end

                    rdmx_pkg::fd_header, rdmx_pkg::md_header, rdmx_pkg::fc_header:
                        if (beat.valid) begin
                            if (beat.well_formed) begin
                                if (beat.magic != rdmx_pkg::rdmx_magic)
                                    error[err_base + rdmx_pkg::err_fd_magic] <= 1'b1;
                                if (beat.seq != exp_seq)
                                    error[err_base + rdmx_pkg::err_fd_seq] <= 1'b1;
                                if (beat.ip4_length != exp_ip4_length)
                                    error[err_base + rdmx_pkg::err_fd_psize] <= 1'b1;
                                if (beat.address != exp_addr)
                                    error[err_base + rdmx_pkg::err_fd_taddr] <= 1'b1;
                            end
                            // Strobing here leaves the tracker settled before the next header
                            inc_fd     <= (state == rdmx_pkg::fd_header);
                            inc_md     <= (state == rdmx_pkg::md_header);
                            if (state == rdmx_pkg::fd_header)
                                fd_count <= fd_count + 1'b1;
                            beat_count <= 16'd1;
                            state      <= next_state;
                        end

                    default:
                        if (beat.valid) begin
                            if (beat.well_formed) begin
                                if (state == rdmx_pkg::fd_body && beat.le_data != exp_data)
                                    error[err_base + rdmx_pkg::err_fd_data] <= 1'b1;
                                if (state == rdmx_pkg::fc_body && beat.frame_counter != expected_fc)
                                    error[err_base + rdmx_pkg::err_fd_data] <= 1'b1;
                                if (beat.last && beat_count != exp_beats)
                                    error[err_base + rdmx_pkg::err_fd_plen] <= 1'b1;
                            end
                            if (beat.last)
                                state <= next_state;
                        end
                endcase
            end
        end
    end

endmodule

/* verilog/rdmx_checker_top.sv */
/*
 * RDMX receive checker top level for one Ethernet channel
 */
`timescale 1ns/10ps

module rdmx_checker_top (
    input  logic                        clk,
    input  logic                        resetn,
    // Frame-data pattern stream
    input  logic [31:0]                 pattern_data,
    input  logic                        pattern_valid,
    output logic                        pattern_ready,
    // Ethernet beat stream from the MAC
    input  logic [rdmx_pkg::beat_w-1:0] eth_data,
    input  logic                        eth_valid,
    input  logic                        eth_last,
    input  logic                        eth_user,
    output logic                        eth_ready,
    // Expected sizes, in bytes
    input  logic [15:0]                 packet_size,
    input  logic [31:0]                 frame_size,
    // Target address windows
    input  rdmx_pkg::addr_t             rfd_addr,
    input  rdmx_pkg::addr_t             rfd_size,
    input  rdmx_pkg::addr_t             rmd_addr,
    input  rdmx_pkg::addr_t             rmd_size,
    input  rdmx_pkg::addr_t             rfc_addr,
    // Status
    output rdmx_pkg::count_t            total_packets,
    output rdmx_pkg::count_t            malformed_packets,
    output logic [31:0]                 expected_fc,
    output logic [rdmx_pkg::err_w-1:0]  error,
    output logic                        all_good
);

    rdmx_beat_if     beat_if ();
    logic            inc_fd;
    logic            inc_md;
    rdmx_pkg::addr_t fd_addr;
    rdmx_pkg::addr_t md_addr;

    rdmx_ingress rdmx_ingress_i (
        .clk, .eth_data, .eth_valid, .eth_last, .eth_user, .eth_ready,
        .beat (beat_if.src)
    );

    rdmx_addr_tracker rdmx_addr_tracker_i (
        .clk, .resetn, .inc_fd, .inc_md, .packet_size,
        .rfd_addr, .rfd_size, .rmd_addr, .rmd_size,
        .fd_addr, .md_addr
    );

    // The checker owns both ready outputs
    rdmx_frame_checker rdmx_frame_checker_i (
        .clk, .resetn,
        .beat (beat_if.dst),
        .pattern_data, .pattern_valid, .packet_size, .frame_size,
        .fd_addr, .md_addr, .rfc_addr,
        .pattern_ready, .eth_ready, .inc_fd, .inc_md,
        .total_packets, .malformed_packets, .expected_fc, .error, .all_good
    );

endmodule

/* sim/rdmx_checker_tb.sv */
/*
 * Testbench for the RDMX receive checker that replays the golden file,
 * builds header beats from its fields and checks counters and error bits
 */
`timescale 1ns/10ps

module rdmx_checker_tb;

    logic                        clk = 1'b0;
    logic                        resetn;
    logic [31:0]                 pattern_data;
    logic                        pattern_valid;
    logic                        pattern_ready;
    logic [rdmx_pkg::beat_w-1:0] eth_data;
    logic                        eth_valid;
    logic                        eth_last;
    logic                        eth_user;
    logic                        eth_ready;
    logic [15:0]                 packet_size;
    logic [31:0]                 frame_size;
    rdmx_pkg::addr_t             rfd_addr;
    rdmx_pkg::addr_t             rfd_size;
    rdmx_pkg::addr_t             rmd_addr;
    rdmx_pkg::addr_t             rmd_size;
    rdmx_pkg::addr_t             rfc_addr;
    rdmx_pkg::count_t            total_packets;
    rdmx_pkg::count_t            malformed_packets;
    logic [31:0]                 expected_fc;
    logic [rdmx_pkg::err_w-1:0]  error;
    logic                        all_good;

    // The watchdog limit is set once the golden file has been counted
    int                          cycle_count = 0;
    int                          cycle_limit = 0;
    int                          checks_done = 0;
    // Rest of a golden file line that is skipped
    logic [8*256-1:0]            rest;

    rdmx_checker_top rdmx_checker_top_i (.*);

    // 20 ns clock period
    always #10 clk = ~clk;

    // ========================================
    // Watchdog
    // ========================================
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic open_golden(output int fd);
        fd = $fopen("sim/rdmx_checker_golden.txt", "r");
        if (fd == 0)
            stop_on_error("cannot open the golden file sim/rdmx_checker_golden.txt");
    endtask

    // Header fields go in network order, so the beat is built big-endian and then
    // byte-reversed into the order the MAC delivers
    function automatic logic [rdmx_pkg::beat_w-1:0] header_beat(
        input logic [15:0] magic, input logic [15:0] seq,
        input logic [15:0] ip4_length, input logic [63:0] address);
        logic [rdmx_pkg::beat_w-1:0] be;
        logic [rdmx_pkg::beat_w-1:0] le;
        be = '0;
        be[rdmx_pkg::pos_ip4_length +: 16]   = ip4_length;
        be[rdmx_pkg::pos_rdmx_magic +: 16]   = magic;
        be[rdmx_pkg::pos_rdmx_address +: 64] = address;
        be[rdmx_pkg::pos_rdmx_seq +: 16]     = seq;
        for (int i = 0; i < 64; i++)
            le[8*i +: 8] = be[504 - 8*i +: 8];
        return le;
    endfunction

    // ========================================
    // Stimulus tasks
    // ========================================
    // Every task starts and ends 2 ns after a rising edge
    task automatic apply_reset();
        eth_valid     = 1'b0;
        pattern_valid = 1'b0;
        resetn        = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        resetn = 1'b1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
        #2;
    endtask

    // Ready is stable between edges, so it is sampled on the falling edge
    task automatic wait_ready(input logic is_eth);
        logic rdy;
        rdy = 1'b0;
        while (!rdy) begin
            @(negedge clk);
            rdy = is_eth ? eth_ready : pattern_ready;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_pattern(input logic [31:0] word);
        pattern_data  = word;
        pattern_valid = 1'b1;
        wait_ready(1'b0);
        pattern_valid = 1'b0;
    endtask

    task automatic send_beat(input logic [rdmx_pkg::beat_w-1:0] data, input logic last,
                             input logic user);
        eth_data  = data;
        eth_last  = last;
        eth_user  = user;
        eth_valid = 1'b1;
        wait_ready(1'b1);
    endtask

    // One header beat, then body beats carrying the word sixteen times
    task automatic send_packet(input logic [63:0] f [7]);
        send_beat(header_beat(f[0][15:0], f[1][15:0], f[2][15:0], f[3]), 1'b0, f[6][0]);
        for (int i = 1; i <= int'(f[5]); i++)
            send_beat({16{f[4][31:0]}}, i == int'(f[5]), f[6][0]);
        eth_valid = 1'b0;
        eth_last  = 1'b0;
        eth_user  = 1'b0;
    endtask

    task automatic check_result(input logic [63:0] f [7]);
        idle(4);
        check_value("total_packets", total_packets, f[0]);
        check_value("malformed_packets", malformed_packets, f[1]);
        check_value("expected_fc", 64'(expected_fc), f[2]);
        check_value("error", 64'(error), f[3]);
        check_value("all_good", 64'(all_good), 64'(f[3] == 0));
        // A set error bit opens both streams so they drain
        if (f[3] != 0) begin
            check_value("pattern_ready", 64'(pattern_ready), 64'd1);
            check_value("eth_ready", 64'(eth_ready), 64'd1);
        end
        checks_done++;
    endtask

    // ========================================
    // Golden file replay
    // ========================================
    initial begin
        int          fd;
        int          n;
        int          records;
        byte         kind;
        logic [63:0] f [7];

        resetn        = 1'b0;
        pattern_data  = '0;
        pattern_valid = 1'b0;
        eth_data      = '0;
        eth_valid     = 1'b0;
        eth_last      = 1'b0;
        eth_user      = 1'b0;
        // Two 2-beat frame-data packets per half-frame and small wrapping windows
        packet_size   = 16'd128;
        frame_size    = 32'd512;
        rfd_addr      = 64'h1000;
        rfd_size      = 64'h100;
        rmd_addr      = 64'h2000;
        rmd_size      = 64'h100;
        rfc_addr      = 64'h3000;

        // First pass counts the records to size the watchdog
        records = 0;
        open_golden(fd);
        while ($fscanf(fd, " %c", kind) == 1) begin
            if (kind != "#")
                records++;
            n = $fgets(rest, fd);
        end
        $fclose(fd);
        cycle_limit = 50 * (records + 1);

        apply_reset();
        open_golden(fd);
        while ($fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "#": n = $fgets(rest, fd);
                "P": begin
                    n = $fscanf(fd, " %h", f[0]);
                    if (n != 1)
                        stop_on_error("a pattern record in the golden file is incomplete");
                    send_pattern(f[0][31:0]);
                end
                "B": begin
                    n = $fscanf(fd, " %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                    if (n != 7)
                        stop_on_error("a packet record in the golden file is incomplete");
                    send_packet(f);
                end
                "R": apply_reset();
                "E": begin
                    n = $fscanf(fd, " %h %h %h %h", f[0], f[1], f[2], f[3]);
                    if (n != 4)
                        stop_on_error("an expected result record is incomplete");
                    check_result(f);
                end
                default: stop_on_error("the golden file holds an unknown record type");
            endcase
        end
        $fclose(fd);

        if (checks_done > 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("The golden file holds no expected result record");
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

endmodule

/* sim/rdmx_checker_golden.txt */
# P word | B magic seq ip4_length address word body_beats user | R | E total malformed fc error
# B is one packet: a header beat, then body beats of word x16, last on the final beat
# Two clean frames, frame-data addresses wrap, second meta-data at rmd_addr + 128
P a5a50001
B 0122 0001 00b2 1000 a5a50001 2 0
B 0122 0002 00b2 1080 a5a50001 2 0
B 0122 0003 00b2 2000 00000000 2 0
B 0122 0004 0036 3000 00000001 1 0
P 5a5a0002
B 0122 0005 00b2 1000 5a5a0002 2 0
B 0122 0006 00b2 1080 5a5a0002 2 0
B 0122 0007 00b2 2080 00000000 2 0
B 0122 0008 0036 3000 00000002 1 0
E 8 0 2 0
# Frame-data body mismatch, the meta-data packet after it drains
R
P 11110003
B 0122 0001 00b2 1000 11110003 2 0
B 0122 0002 00b2 1080 11110bad 2 0
B 0122 0003 00b2 2000 00000000 2 0
E 1 0 1 10
# Wrong sequence number
R
P 22220004
B 0122 0001 00b2 1000 22220004 2 0
B 0122 0005 00b2 1080 22220004 2 0
E 1 0 1 2
# Wrong meta-data target address
R
P 33330005
B 0122 0001 00b2 1000 33330005 2 0
B 0122 0002 00b2 1080 33330005 2 0
B 0122 0003 00b2 2080 00000000 2 0
E 2 0 1 200
# Bad FCS packet with a corrupt header is counted but not checked
R
P 44440006
B 0122 0001 00b2 1000 44440006 2 0
B dead 0002 00b2 1080 00000000 2 1
B 0122 0003 00b2 2000 00000000 2 0
B 0122 0004 0036 3000 00000001 1 0
E 4 1 1 0
# Wrong frame counter
R
P 55550007
B 0122 0001 00b2 1000 55550007 2 0
B 0122 0002 00b2 1080 55550007 2 0
B 0122 0003 00b2 2000 00000000 2 0
B 0122 0004 0036 3000 00000007 1 0
E 4 0 1 10000
# Meta-data packet with three body beats
R
P 66660008
B 0122 0001 00b2 1000 66660008 2 0
B 0122 0002 00b2 1080 66660008 2 0
B 0122 0003 00b2 2000 00000000 3 0
E 3 0 1 800
# Bad FCS packets after the error are still counted
B 0000 0000 0000 0000 00000000 2 1
B 0000 0000 0000 0000 00000000 1 1
E 3 2 1 800

/* sources.f */
verilog/rdmx_pkg.sv
verilog/rdmx_beat_if.sv
verilog/rdmx_ingress.sv
verilog/rdmx_addr_tracker.sv
verilog/rdmx_frame_checker.sv
verilog/rdmx_checker_top.sv
sim/rdmx_checker_tb.sv

/* Bender.yml */
package:
  name: rdmx_checker

sources:
  - verilog/rdmx_pkg.sv
  - verilog/rdmx_beat_if.sv
  - verilog/rdmx_ingress.sv
  - verilog/rdmx_addr_tracker.sv
  - verilog/rdmx_frame_checker.sv
  - verilog/rdmx_checker_top.sv
  - target: test
    files:
      - sim/rdmx_checker_tb.sv
